//--- dccm_pkg.sv
// DCCM controller shared definitions
package dccm_pkg;

   // --------------------------------------------------
   // data word geometry
   // --------------------------------------------------
   localparam int DATA_W  = 32;                   // data word width
   localparam int BYTE_W  = 8;                    // width of one byte lane
   localparam int BYTES_W = DATA_W / BYTE_W;      // byte lanes per word, 4
   localparam int LANE_W  = $clog2(BYTES_W);      // byte offset within a word

   // --------------------------------------------------
   // memory and store buffer sizing
   // --------------------------------------------------
   localparam int ADDR_W   = 10;                  // word address, 1024 words
   localparam int SB_DEPTH = 4;                   // store buffer entries
   localparam int SB_PTR_W = 2;                   // store buffer pointer width
   localparam int SB_CNT_W = SB_PTR_W + 1;        // occupancy counts 0..SB_DEPTH

   // --------------------------------------------------
   // front end FSM encoding
   // --------------------------------------------------
   localparam int FE_STATE_W = 2;
   localparam logic [FE_STATE_W-1:0] FE_IDLE = 2'd0;   // waiting for a host request
   localparam logic [FE_STATE_W-1:0] FE_LOAD = 2'd1;   // load in the read pipe
   localparam logic [FE_STATE_W-1:0] FE_FULL = 2'd2;   // store held off by full buffer
   localparam logic [FE_STATE_W-1:0] FE_SACK = 2'd3;   // store ack cycle

   // one data word, seen whole or lane by lane
   typedef union packed {
      logic [DATA_W-1:0]              word;
      logic [BYTES_W-1:0][BYTE_W-1:0] bytes;
   } dccm_word_u;

endpackage

//--- sb_ifs.sv
// Store buffer interfaces

// oldest store buffer entry offered to the memory port
interface sb_drain_if;
   logic                          drain_req;      // oldest entry valid
   logic [dccm_pkg::ADDR_W-1:0]   drain_addr;
   logic [dccm_pkg::DATA_W-1:0]   drain_data;
   logic [dccm_pkg::BYTES_W-1:0]  drain_sel;
   logic                          drain_grant;    // entry retires when both high

   modport buffer (
      output drain_req, drain_addr, drain_data, drain_sel,
      input  drain_grant
   );

   modport arb (
      input  drain_req, drain_addr, drain_data, drain_sel,
      output drain_grant
   );
endinterface

// load lookup against pending stores
interface sb_fwd_if;
   logic [dccm_pkg::ADDR_W-1:0]   fwd_addr;       // word address of the load
   logic [dccm_pkg::DATA_W-1:0]   fwd_data;       // newest pending byte per lane
   logic [dccm_pkg::BYTES_W-1:0]  fwd_sel;        // lanes that hit in the buffer

   modport req (
      output fwd_addr
   );

   modport buffer (
      input  fwd_addr,
      output fwd_data, fwd_sel
   );

   modport mon (
      input  fwd_data, fwd_sel
   );
endinterface

//--- dccm_ram.sv
// Single-ported data memory
module dccm_ram (
   input  logic                         clk,
   input  logic                         rd_en,
   input  logic                         wr_en,
   input  logic [dccm_pkg::ADDR_W-1:0]  addr,       // shared by read and write
   input  logic [dccm_pkg::DATA_W-1:0]  wr_data,
   input  logic [dccm_pkg::BYTES_W-1:0] wr_sel,
   output logic [dccm_pkg::DATA_W-1:0]  rd_data
);

   dccm_pkg::dccm_word_u mem [2**dccm_pkg::ADDR_W];
   dccm_pkg::dccm_word_u wr_word;

   assign wr_word.word = wr_data;

   // --------------------------------------------------
   // byte-lane write, registered read
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = 0; i < dccm_pkg::BYTES_W; i++) begin
            if (wr_sel[i]) begin
               mem[addr].bytes[i] <= wr_word.bytes[i];
            end
         end
      end
      if (rd_en) begin
         rd_data <= mem[addr].word;               // one cycle read latency
      end
   end

endmodule

//--- store_buffer.sv
// Store buffer with forwarding lookup
module store_buffer (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         enq,
   input  logic [dccm_pkg::ADDR_W-1:0]  enq_addr,
   input  logic [dccm_pkg::DATA_W-1:0]  enq_data,
   input  logic [dccm_pkg::BYTES_W-1:0] enq_sel,
   output logic                         full,
   sb_drain_if.buffer                   drain,
   sb_fwd_if.buffer                     fwd
);

   logic [dccm_pkg::ADDR_W-1:0]  ent_addr [dccm_pkg::SB_DEPTH];
   dccm_pkg::dccm_word_u         ent_data [dccm_pkg::SB_DEPTH];
   logic [dccm_pkg::BYTES_W-1:0] ent_sel  [dccm_pkg::SB_DEPTH];

   logic [dccm_pkg::SB_PTR_W-1:0] wr_ptr;
   logic [dccm_pkg::SB_PTR_W-1:0] rd_ptr;          // oldest entry
   logic [dccm_pkg::SB_CNT_W-1:0] count;
   logic                          push;
   logic                          pop;

   dccm_pkg::dccm_word_u          fwd_word;
   logic [dccm_pkg::BYTES_W-1:0]  fwd_lanes;

   assign full = (int'(count) == dccm_pkg::SB_DEPTH);
   assign push = enq & ~full;                       // a same-edge drain does not free a slot
   assign pop  = drain.drain_req & drain.drain_grant;

   // --------------------------------------------------
   // FIFO control
   // --------------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;               // wraps with the pointer width
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         ent_addr[wr_ptr]      <= enq_addr;
         ent_data[wr_ptr].word <= enq_data;
         ent_sel[wr_ptr]       <= enq_sel;
      end
   end

   assign drain.drain_req  = (count != '0);
   assign drain.drain_addr = ent_addr[rd_ptr];
   assign drain.drain_data = ent_data[rd_ptr].word;
   assign drain.drain_sel  = ent_sel[rd_ptr];

   // --------------------------------------------------
   // byte-wise forwarding, oldest to newest
   // --------------------------------------------------
   always_comb begin
      logic [dccm_pkg::SB_PTR_W-1:0] idx;
      fwd_word.word = '0;
      fwd_lanes     = '0;
      for (int i = 0; i < dccm_pkg::SB_DEPTH; i++) begin
         idx = rd_ptr + i[dccm_pkg::SB_PTR_W-1:0];
         if ((i < int'(count)) && (ent_addr[idx] == fwd.fwd_addr)) begin
            for (int b = 0; b < dccm_pkg::BYTES_W; b++) begin
               if (ent_sel[idx][b]) begin
                  fwd_word.bytes[b] = ent_data[idx].bytes[b];   // newer entry overrides
                  fwd_lanes[b]      = 1'b1;
               end
            end
         end
      end
   end

   assign fwd.fwd_data = fwd_word.word;
   assign fwd.fwd_sel  = fwd_lanes;

endmodule

//--- load_merge.sv
// Load data merge and alignment
module load_merge (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         issue,
   input  logic [dccm_pkg::BYTES_W-1:0] issue_sel,
   sb_fwd_if.mon                        fwd,
   input  logic [dccm_pkg::DATA_W-1:0]  ram_rd_data,
   output logic [dccm_pkg::DATA_W-1:0]  load_data
);

   dccm_pkg::dccm_word_u         fwd_data_q;
   logic [dccm_pkg::BYTES_W-1:0] fwd_sel_q;
   logic [dccm_pkg::BYTES_W-1:0] keep_q;           // result lanes after the shift
   logic [dccm_pkg::LANE_W-1:0]  shift;
   logic [dccm_pkg::LANE_W-1:0]  shift_q;
   logic                         merge_vld;        // memory data arrives this cycle

   dccm_pkg::dccm_word_u         ram_word;
   dccm_pkg::dccm_word_u         merged;
   dccm_pkg::dccm_word_u         shifted;
   dccm_pkg::dccm_word_u         result;

   // lowest selected lane is the byte offset
   always_comb begin
      shift = '0;
      for (int i = dccm_pkg::BYTES_W - 1; i >= 0; i--) begin
         if (issue_sel[i]) begin
            shift = i[dccm_pkg::LANE_W-1:0];
         end
      end
   end

   // --------------------------------------------------
   // issue stage capture
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (issue) begin
         fwd_data_q.word <= fwd.fwd_data;
         fwd_sel_q       <= fwd.fwd_sel;
         shift_q         <= shift;
         keep_q          <= issue_sel >> shift;   // access size, right-justified
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         merge_vld <= 1'b0;
      end else begin
         merge_vld <= issue;
      end
   end

   // --------------------------------------------------
   // merge, align and zero the upper bytes
   // --------------------------------------------------
   assign ram_word.word = ram_rd_data;

   always_comb begin
      for (int i = 0; i < dccm_pkg::BYTES_W; i++) begin
         merged.bytes[i] = fwd_sel_q[i] ? fwd_data_q.bytes[i] : ram_word.bytes[i];
      end
   end

   assign shifted.word = merged.word >> (dccm_pkg::BYTE_W * shift_q);

   always_comb begin
      for (int i = 0; i < dccm_pkg::BYTES_W; i++) begin
         result.bytes[i] = keep_q[i] ? shifted.bytes[i] : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (merge_vld) begin
         load_data <= result.word;                // shows with the ack
      end
   end

endmodule

//--- lsu_wb_front.sv
// Wishbone front end and DCCM port arbiter
module lsu_wb_front (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         wb_cyc,
   input  logic                         wb_stb,
   input  logic                         wb_we,
   input  logic [dccm_pkg::ADDR_W-1:0]  wb_adr,
   input  logic [dccm_pkg::BYTES_W-1:0] wb_sel,
   input  logic [dccm_pkg::DATA_W-1:0]  wb_dat_i,
   output logic                         wb_ack,
   sb_drain_if.arb                      drain,
   sb_fwd_if.req                        fwd,
   output logic                         enq,
   output logic [dccm_pkg::ADDR_W-1:0]  enq_addr,
   output logic [dccm_pkg::DATA_W-1:0]  enq_data,
   output logic [dccm_pkg::BYTES_W-1:0] enq_sel,
   input  logic                         full,
   output logic                         ram_rd_en,
   output logic                         ram_wr_en,
   output logic [dccm_pkg::ADDR_W-1:0]  ram_addr,
   output logic [dccm_pkg::DATA_W-1:0]  ram_wr_data,
   output logic [dccm_pkg::BYTES_W-1:0] ram_wr_sel,
   output logic                         issue,       // load enters the read pipe
   output logic [dccm_pkg::BYTES_W-1:0] issue_sel
);

   logic [dccm_pkg::FE_STATE_W-1:0] state;
   logic [dccm_pkg::FE_STATE_W-1:0] state_nxt;
   logic [1:0]                      ld_pend;        // loads in flight, bit 1 is the ack stage
   logic                            req;
   logic                            st_try;

   // --------------------------------------------------
   // request decode
   // --------------------------------------------------
   assign req    = wb_cyc & wb_stb & ~wb_ack;                   // stb ignored in the ack cycle
   assign issue  = (state == dccm_pkg::FE_IDLE) & req & ~wb_we;
   assign st_try = ((state == dccm_pkg::FE_IDLE) & req & wb_we) |
                   (state == dccm_pkg::FE_FULL);                 // host still holds the store
   assign enq    = st_try & ~full;

   assign enq_addr  = wb_adr;
   assign enq_data  = wb_dat_i;
   assign enq_sel   = wb_sel;
   assign issue_sel = wb_sel;
   assign fwd.fwd_addr = wb_adr;                                 // lookup in the issue cycle

   always_comb begin
      state_nxt = state;
      case (state)
         dccm_pkg::FE_IDLE: begin
            if (req) begin
               if (!wb_we) begin
                  state_nxt = dccm_pkg::FE_LOAD;
               end else if (full) begin
                  state_nxt = dccm_pkg::FE_FULL;
               end else begin
                  state_nxt = dccm_pkg::FE_SACK;
               end
            end
         end
         dccm_pkg::FE_LOAD: begin
            if (ld_pend[1]) begin
               state_nxt = dccm_pkg::FE_IDLE;              // ack goes out this cycle
            end
         end
         dccm_pkg::FE_FULL: begin
            if (!full) begin
               state_nxt = dccm_pkg::FE_SACK;
            end
         end
         default: begin
            state_nxt = dccm_pkg::FE_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= dccm_pkg::FE_IDLE;
         ld_pend <= 2'b00;
      end else begin
         state   <= state_nxt;
         ld_pend <= {ld_pend[0], issue};
      end
   end

   assign wb_ack = ld_pend[1] | (state == dccm_pkg::FE_SACK);

   // --------------------------------------------------
   // memory port, load read wins over store commit
   // --------------------------------------------------
   assign drain.drain_grant = drain.drain_req & ~issue;
   assign ram_rd_en   = issue;
   assign ram_wr_en   = drain.drain_grant;
   assign ram_addr    = issue ? wb_adr : drain.drain_addr;
   assign ram_wr_data = drain.drain_data;
   assign ram_wr_sel  = drain.drain_sel;

endmodule

//--- dccm_ctl_top.sv
// DCCM controller top level
module dccm_ctl_top (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         wb_cyc,
   input  logic                         wb_stb,
   input  logic                         wb_we,
   input  logic [dccm_pkg::ADDR_W-1:0]  wb_adr,      // word address
   input  logic [dccm_pkg::BYTES_W-1:0] wb_sel,
   input  logic [dccm_pkg::DATA_W-1:0]  wb_dat_i,
   output logic [dccm_pkg::DATA_W-1:0]  wb_dat_o,    // right-justified load data
   output logic                         wb_ack
);

   logic                         enq;
   logic [dccm_pkg::ADDR_W-1:0]  enq_addr;
   logic [dccm_pkg::DATA_W-1:0]  enq_data;
   logic [dccm_pkg::BYTES_W-1:0] enq_sel;
   logic                         full;

   logic                         ram_rd_en;
   logic                         ram_wr_en;
   logic [dccm_pkg::ADDR_W-1:0]  ram_addr;
   logic [dccm_pkg::DATA_W-1:0]  ram_wr_data;
   logic [dccm_pkg::BYTES_W-1:0] ram_wr_sel;
   logic [dccm_pkg::DATA_W-1:0]  ram_rd_data;

   logic                         issue;
   logic [dccm_pkg::BYTES_W-1:0] issue_sel;

   sb_drain_if drain_if ();
   sb_fwd_if   fwd_if ();

   lsu_wb_front lsu_wb_front_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_sel      (wb_sel),
      .wb_dat_i    (wb_dat_i),
      .wb_ack      (wb_ack),
      .drain       (drain_if),
      .fwd         (fwd_if),
      .enq         (enq),
      .enq_addr    (enq_addr),
      .enq_data    (enq_data),
      .enq_sel     (enq_sel),
      .full        (full),
      .ram_rd_en   (ram_rd_en),
      .ram_wr_en   (ram_wr_en),
      .ram_addr    (ram_addr),
      .ram_wr_data (ram_wr_data),
      .ram_wr_sel  (ram_wr_sel),
      .issue       (issue),
      .issue_sel   (issue_sel)
   );

   store_buffer store_buffer_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .enq      (enq),
      .enq_addr (enq_addr),
      .enq_data (enq_data),
      .enq_sel  (enq_sel),
      .full     (full),
      .drain    (drain_if),
      .fwd      (fwd_if)
   );

   load_merge load_merge_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .issue       (issue),
      .issue_sel   (issue_sel),
      .fwd         (fwd_if),
      .ram_rd_data (ram_rd_data),
      .load_data   (wb_dat_o)
   );

   dccm_ram dccm_ram_i (
      .clk     (clk),
      .rd_en   (ram_rd_en),
      .wr_en   (ram_wr_en),
      .addr    (ram_addr),
      .wr_data (ram_wr_data),
      .wr_sel  (ram_wr_sel),
      .rd_data (ram_rd_data)
   );

endmodule

//--- tb_clkgen.sv
// Testbench clock and reset
module tb_clkgen (
   output logic clk,
   output logic arst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   // reset held over 10 rising edges, released on a falling edge
   initial begin
      arst_n = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

//--- tb_dccm_ctl.sv
// DCCM controller testbench
module tb_dccm_ctl;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ACK_WAIT    = 40;                       // cycles allowed per request
   localparam int N_REQ       = 364;                      // 16 + 8 + 8 + 16 + 316
   localparam int RST_CYCLES  = 10;
   localparam int CYCLE_LIMIT = ACK_WAIT * N_REQ + RST_CYCLES;

   localparam logic [dccm_pkg::ADDR_W-1:0] BASE_SL  = 'h030;   // store then load
   localparam logic [dccm_pkg::ADDR_W-1:0] BASE_BH  = 'h020;   // byte and half loads
   localparam logic [dccm_pkg::ADDR_W-1:0] BASE_MO  = 'h050;   // merge order
   localparam logic [dccm_pkg::ADDR_W-1:0] BASE_BP  = 'h080;   // back-pressure
   localparam logic [dccm_pkg::ADDR_W-1:0] BASE_RND = 'h100;   // random mix, 16 words

   logic                          clk;
   logic                          arst_n;
   logic                          wb_cyc;
   logic                          wb_stb;
   logic                          wb_we;
   logic [dccm_pkg::ADDR_W-1:0]   wb_adr;
   logic [dccm_pkg::BYTES_W-1:0]  wb_sel;
   logic [dccm_pkg::DATA_W-1:0]   wb_dat_i;
   logic [dccm_pkg::DATA_W-1:0]   wb_dat_o;
   logic                          wb_ack;

   logic [dccm_pkg::DATA_W-1:0]   model [2**dccm_pkg::ADDR_W];   // updated at store ack

   integer                        seed;
   string                         test_name;
   int                            cycle_cnt;
   int                            req_cycle;        // cycle count when the request was driven
   int                            req_cnt;
   int                            err_cnt;
   int                            pass_cnt;
   int                            lat_cnt;
   int                            lat_err;
   int                            test_req;
   int                            test_err;

   // request in flight, handed from the driver to the compare process
   logic                          busy;
   logic                          cur_we;
   logic [dccm_pkg::ADDR_W-1:0]   cur_adr;
   logic [dccm_pkg::BYTES_W-1:0]  cur_sel;
   logic [dccm_pkg::DATA_W-1:0]   cur_dat;
   logic                          ack_prev;         // ack seen at the previous falling edge

   tb_clkgen tb_clkgen_i (
      .clk    (clk),
      .arst_n (arst_n)
   );

   dccm_ctl_top dccm_ctl_top_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_sel   (wb_sel),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack   (wb_ack)
   );

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------
   // selected lanes packed down to bit 0, upper bytes zero
   function automatic logic [31:0] ref_load(logic [31:0] word, logic [3:0] sel);
      logic [31:0] res;
      int          n;
      res = '0;
      n   = 0;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            res[8*n +: 8] = word[8*b +: 8];
            n++;
         end
      end
      return res;
   endfunction

   function automatic logic [3:0] pick_sel(int k);
      case (k)
         0:       return 4'b0001;
         1:       return 4'b0010;
         2:       return 4'b0100;
         3:       return 4'b1000;
         4:       return 4'b0011;
         5:       return 4'b1100;
         default: return 4'b1111;
      endcase
   endfunction

   // --------------------------------------------------
   // host side driver
   // --------------------------------------------------
   task automatic bus_request(input logic we, input logic [dccm_pkg::ADDR_W-1:0] adr,
                              input logic [3:0] sel, input logic [31:0] dat);
      int waited;
      @(negedge clk);
      wb_cyc    = 1'b1;
      wb_stb    = 1'b1;
      wb_we     = we;
      wb_adr    = adr;
      wb_sel    = sel;
      wb_dat_i  = dat;
      cur_we    = we;
      cur_adr   = adr;
      cur_sel   = sel;
      cur_dat   = dat;
      req_cycle = cycle_cnt;
      busy      = 1'b1;
      req_cnt++;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!wb_ack && waited < ACK_WAIT);
      if (!wb_ack) begin
         $display("%s: no ack for request at adr %h within %0d cycles",
                  test_name, adr, ACK_WAIT);
         err_cnt++;
         busy = 1'b0;
      end
   endtask                                              // returns in the ack cycle

   task automatic write_word(input logic [dccm_pkg::ADDR_W-1:0] adr, input logic [3:0] sel,
                             input logic [31:0] dat);
      bus_request(1'b1, adr, sel, dat);
   endtask

   task automatic read_lanes(input logic [dccm_pkg::ADDR_W-1:0] adr, input logic [3:0] sel);
      logic [31:0] junk;
      junk = $random(seed);                              // write data is don't care on loads
      bus_request(1'b0, adr, sel, junk);
   endtask

   task automatic idle_bus(input int n);
      repeat (n) begin
         @(negedge clk);
         wb_cyc = 1'b0;
         wb_stb = 1'b0;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_req  = req_cnt;
      test_err  = err_cnt;
   endtask

   task automatic close_test();
      idle_bus(2);                                       // last ack is checked by now
      $display("test %s: %0d requests, %0d errors", test_name,
               req_cnt - test_req, err_cnt - test_err);
   endtask

   // --------------------------------------------------
   // compare process, sampled on the falling edge
   // --------------------------------------------------
   always @(negedge clk) begin : check_acks
      logic [31:0] exp_val;
      if (arst_n && wb_ack) begin
         if (ack_prev) begin
            $display("%s: ack held high for more than one cycle at cycle %0d",
                     test_name, cycle_cnt);
            err_cnt++;
         end else if (!busy) begin
            $display("%s: ack at cycle %0d with no request outstanding",
                     test_name, cycle_cnt);
            err_cnt++;
         end else begin
            busy = 1'b0;
            if (cur_we) begin
               for (int b = 0; b < 4; b++) begin
                  if (cur_sel[b]) begin
                     model[cur_adr][8*b +: 8] = cur_dat[8*b +: 8];
                  end
               end
            end else begin
               exp_val = ref_load(model[cur_adr], cur_sel);
               lat_cnt++;
               if (cycle_cnt - req_cycle != 2) begin
                  $display("ERR %s load latency adr=%h expected=2 actual=%0d",
                           test_name, cur_adr, cycle_cnt - req_cycle);
                  lat_err++;
                  err_cnt++;
               end
               if (wb_dat_o !== exp_val) begin
                  $display("ERR %s adr=%h sel=%b expected=%h actual=%h",
                           test_name, cur_adr, cur_sel, exp_val, wb_dat_o);
                  err_cnt++;
               end else begin
                  pass_cnt++;
               end
            end
         end
      end
      ack_prev = arst_n && wb_ack;
   end

   // cycle counter and run limit
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("run stopped after %0d cycles without finishing the tests", cycle_cnt);
         $display("Verification failed");
         $finish;
      end
   end

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   initial begin
      logic [31:0] r;
      logic [31:0] dat;
      int          ofs;
      seed      = 32'hf001_8419;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_sel    = '0;
      wb_dat_i  = '0;
      busy      = 1'b0;
      ack_prev  = 1'b0;
      cycle_cnt = 0;
      req_cycle = 0;
      req_cnt   = 0;
      err_cnt   = 0;
      pass_cnt  = 0;
      lat_cnt   = 0;
      lat_err   = 0;
      wait (arst_n === 1'b1);

      start_test("store_load");
      for (int i = 0; i < 8; i++) begin
         dat = $random(seed);
         write_word(BASE_SL + i[dccm_pkg::ADDR_W-1:0], 4'b1111, dat);
         if (i >= 4) begin
            idle_bus(6);                                 // let the entry drain first
         end
         read_lanes(BASE_SL + i[dccm_pkg::ADDR_W-1:0], 4'b1111);
      end
      close_test();

      start_test("byte_half");
      write_word(BASE_BH, 4'b1111, 32'h8877_6655);
      for (int k = 0; k < 7; k++) begin
         read_lanes(BASE_BH, pick_sel(k));
      end
      close_test();

      // junk in the unselected lanes must not land anywhere
      start_test("merge_order");
      write_word(BASE_MO, 4'b1111, 32'h1122_3344);
      write_word(BASE_MO, 4'b0011, 32'hdead_5566);
      write_word(BASE_MO, 4'b0100, 32'hbe77_efbe);
      write_word(BASE_MO, 4'b0001, 32'hcafe_f088);
      write_word(BASE_MO, 4'b1100, 32'h99aa_0bad);
      read_lanes(BASE_MO, 4'b1111);
      idle_bus(6);
      read_lanes(BASE_MO, 4'b1111);
      read_lanes(BASE_MO, 4'b0100);
      close_test();

      start_test("back_pressure");
      for (int i = 0; i < 8; i++) begin
         dat = $random(seed);
         write_word(BASE_BP + i[dccm_pkg::ADDR_W-1:0], 4'b1111, dat);
      end
      idle_bus(8);
      for (int i = 0; i < 8; i++) begin
         read_lanes(BASE_BP + i[dccm_pkg::ADDR_W-1:0], 4'b1111);
      end
      close_test();

      start_test("random_mix");
      for (int i = 0; i < 16; i++) begin
         dat = $random(seed);
         write_word(BASE_RND + i[dccm_pkg::ADDR_W-1:0], 4'b1111, dat);
      end
      for (int i = 0; i < 300; i++) begin
         r   = $random(seed);
         dat = $random(seed);
         ofs = int'(r[3:0]);
         if (r[31]) begin
            write_word(BASE_RND + ofs[dccm_pkg::ADDR_W-1:0], pick_sel(int'(r[15:8]) % 7), dat);
         end else begin
            read_lanes(BASE_RND + ofs[dccm_pkg::ADDR_W-1:0], pick_sel(int'(r[15:8]) % 7));
         end
      end
      close_test();

      $display("test load_latency: %0d loads, %0d errors", lat_cnt, lat_err);
      $display("checks passed: %0d, checks failed: %0d", pass_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- sim.f
dccm_pkg.sv
sb_ifs.sv
dccm_ram.sv
store_buffer.sv
load_merge.sv
lsu_wb_front.sv
dccm_ctl_top.sv
tb_clkgen.sv
tb_dccm_ctl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DCCM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps --top-module tb_dccm_ctl \
   -f sim.f -o sim_bin > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/sim_bin > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Verification failed" sim.log; then
   exit 1
fi
if ! grep -q "Verification passed" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0
